// ==== src/mvu_params.svh ====
`ifndef MVU_PARAMS_SVH
`define MVU_PARAMS_SVH

// Bank address width, shared by the data and weight banks
`define MVU_BADDR               10

// Dimension length field, holds length minus one
`define MVU_BLEN                8

// Job length counter
`define MVU_BCNT                16

// Output precision field, holds bits minus one
`define MVU_BPREC               4

`define MVU_NJUMPS              3

// VVP pipeline stages (2) + memory read latency (1) + 1
`define MVU_PIPE_DELAY          4

// Scaler latency (2) + max pool stages (1)
`define MVU_POST_DELAY          3

// Accumulator done on j1 unless the job says otherwise
`define MVU_LOAD_SEL_DEFAULT    3'b010

`endif

// ==== src/mvu_pkg.sv ====
`default_nettype none
`include "mvu_params.svh"

package mvu_pkg;

    // Strides share this type and wrap modulo the bank size
    typedef logic [`MVU_BADDR-1:0]  addr_t;

    typedef logic [`MVU_BLEN-1:0]   len_t;      // Dimension length minus one
    typedef logic [`MVU_BCNT-1:0]   cnt_t;      // Job length in cycles
    typedef logic [`MVU_BPREC-1:0]  prec_t;     // Output precision minus one
    typedef logic [`MVU_NJUMPS-1:0] jump_sel_t; // One-hot jump select

    // Job controller
    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== src/mvu_cfg_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface mvu_cfg_if;

    logic               start_q;    // Start, aligned with the captured fields
    mvu_pkg::cnt_t      countdown;
    mvu_pkg::addr_t     ibase;
    mvu_pkg::addr_t     istride0;
    mvu_pkg::addr_t     istride1;
    mvu_pkg::len_t      ilen0;
    mvu_pkg::len_t      ilen1;
    mvu_pkg::addr_t     wbase;
    mvu_pkg::addr_t     wstride0;
    mvu_pkg::addr_t     wstride1;
    mvu_pkg::len_t      wlen0;
    mvu_pkg::len_t      wlen1;
    mvu_pkg::addr_t     obase;
    mvu_pkg::prec_t     oprec;
    mvu_pkg::jump_sel_t load_sel;   // Jump that marks accumulation done

    // Parameter buffer side
    modport pbuf (output start_q, countdown, ibase, istride0, istride1, ilen0, ilen1,
                  wbase, wstride0, wstride1, wlen0, wlen1, obase, oprec, load_sel);

    modport ctrl (input start_q, countdown);
    modport agu  (input start_q, ibase, istride0, istride1, ilen0, ilen1,
                  wbase, wstride0, wstride1, wlen0, wlen1);
    modport acc  (input start_q, load_sel);
    modport out  (input start_q, obase, oprec);

endinterface

`default_nettype wire

// ==== src/mvu_cfg_buf.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "mvu_params.svh"

module mvu_cfg_buf (
    input  logic               intf,
    input  logic               arst_n,
    input  logic               start,
    input  logic               busy,
    input  mvu_pkg::cnt_t      countdown,
    input  mvu_pkg::addr_t     ibase,
    input  mvu_pkg::addr_t     istride0,
    input  mvu_pkg::addr_t     istride1,
    input  mvu_pkg::len_t      ilen0,
    input  mvu_pkg::len_t      ilen1,
    input  mvu_pkg::addr_t     wbase,
    input  mvu_pkg::addr_t     wstride0,
    input  mvu_pkg::addr_t     wstride1,
    input  mvu_pkg::len_t      wlen0,
    input  mvu_pkg::len_t      wlen1,
    input  mvu_pkg::addr_t     obase,
    input  mvu_pkg::prec_t     oprec,
    input  mvu_pkg::jump_sel_t load_sel,
    mvu_cfg_if.pbuf            cfg
);

    logic accept;

    // A pending start_q also counts as busy
    assign accept = start & ~busy & ~cfg.start_q;

    always_ff @(posedge intf or negedge arst_n) begin
        if (!arst_n) begin
            cfg.start_q  <= 1'b0;
            cfg.load_sel <= `MVU_LOAD_SEL_DEFAULT;
        end else begin
            cfg.start_q <= accept;      // One cycle behind, lines up with the fields
            if (accept) begin
                cfg.load_sel <= load_sel;
            end
        end
    end

    always_ff @(posedge intf) begin
        if (accept) begin
            cfg.countdown <= countdown;
            cfg.ibase     <= ibase;
            cfg.istride0  <= istride0;
            cfg.istride1  <= istride1;
            cfg.ilen0     <= ilen0;
            cfg.ilen1     <= ilen1;
            cfg.wbase     <= wbase;
            cfg.wstride0  <= wstride0;
            cfg.wstride1  <= wstride1;
            cfg.wlen0     <= wlen0;
            cfg.wlen1     <= wlen1;
            cfg.obase     <= obase;
            cfg.oprec     <= oprec;
        end
    end

    // The controller must be idle whenever a job is handed over
    a_start_idle: assert property (@(posedge intf) disable iff (!arst_n)
        cfg.start_q |-> !busy)
        else $error("start_q while the job controller is busy");

endmodule

`default_nettype wire

// ==== src/mvu_job_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module mvu_job_ctrl (
    input  logic    intf,
    input  logic    arst_n,
    mvu_cfg_if.ctrl cfg,
    output logic    busy,
    output logic    run,
    output logic    done,
    output logic    irq
);

    mvu_pkg::ctrl_state_t state;
    mvu_pkg::cnt_t        cnt;          // Run cycles left after this one
    mvu_pkg::cnt_t        run_len;      // Run cycles so far in this job

    always_ff @(posedge intf or negedge arst_n) begin
        if (!arst_n) begin
            state <= mvu_pkg::IDLE;
            cnt   <= '0;
            irq   <= 1'b0;
        end else begin
            case (state)
                mvu_pkg::IDLE: begin
                    if (cfg.start_q) begin
                        state <= mvu_pkg::RUN;
                        cnt   <= cfg.countdown - 1'b1;
                        irq   <= 1'b0;  // Acknowledge the previous job
                    end
                end
                mvu_pkg::RUN: begin
                    if (cnt == '0) begin
                        state <= mvu_pkg::DONE;
                        irq   <= 1'b1;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: state <= mvu_pkg::IDLE;   // DONE lasts one cycle
            endcase
        end
    end

    assign busy = (state != mvu_pkg::IDLE);
    assign run  = (state == mvu_pkg::RUN);
    assign done = (state == mvu_pkg::DONE);

    always_ff @(posedge intf or negedge arst_n) begin
        if (!arst_n) begin
            run_len <= '0;
        end else if (run) begin
            run_len <= run_len + 1'b1;
        end else begin
            run_len <= '0;
        end
    end

    a_run_len: assert property (@(posedge intf) disable iff (!arst_n)
        run |-> (run_len < cfg.countdown))
        else $error("run held longer than countdown");

endmodule

`default_nettype wire

// ==== src/mvu_addr_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module mvu_addr_gen (
    input  logic           intf,
    input  logic           arst_n,
    mvu_cfg_if.agu         cfg,
    input  logic           run,
    output mvu_pkg::addr_t iaddr,
    output mvu_pkg::addr_t waddr,
    output logic           on_j0,
    output logic           on_j1,
    output logic           on_j2
);

    // Channel 0 walks the input bank, channel 1 the weight bank
    mvu_pkg::addr_t base    [2];
    mvu_pkg::addr_t stride0 [2];
    mvu_pkg::addr_t stride1 [2];
    mvu_pkg::len_t  len0    [2];
    mvu_pkg::len_t  len1    [2];
    mvu_pkg::addr_t addr    [2];
    mvu_pkg::len_t  idx0    [2];
    mvu_pkg::len_t  idx1    [2];
    logic [2:0]     jump    [2];    // One-hot step kind: {wrap, dim 1, dim 0}

    assign base[0]    = cfg.ibase;
    assign stride0[0] = cfg.istride0;
    assign stride1[0] = cfg.istride1;
    assign len0[0]    = cfg.ilen0;
    assign len1[0]    = cfg.ilen1;

    assign base[1]    = cfg.wbase;
    assign stride0[1] = cfg.wstride0;
    assign stride1[1] = cfg.wstride1;
    assign len0[1]    = cfg.wlen0;
    assign len1[1]    = cfg.wlen1;

    for (genvar c = 0; c < 2; c++) begin : g_chan
        logic last0;
        logic last1;

        assign last0   = (idx0[c] == len0[c]);
        assign last1   = (idx1[c] == len1[c]);
        assign jump[c] = {3{run}} & {last0 & last1, last0 & ~last1, ~last0};

        always_ff @(posedge intf or negedge arst_n) begin
            if (!arst_n) begin
                addr[c] <= '0;
                idx0[c] <= '0;
                idx1[c] <= '0;
            end else if (cfg.start_q) begin
                addr[c] <= base[c];     // Holds the base in the first run cycle
                idx0[c] <= '0;
                idx1[c] <= '0;
            end else if (jump[c][0]) begin
                addr[c] <= addr[c] + stride0[c];
                idx0[c] <= idx0[c] + 1'b1;
            end else if (jump[c][1]) begin
                addr[c] <= addr[c] + stride1[c];
                idx0[c] <= '0;
                idx1[c] <= idx1[c] + 1'b1;
            end else if (jump[c][2]) begin
                addr[c] <= base[c];     // Both dimensions done, start over
                idx0[c] <= '0;
                idx1[c] <= '0;
            end
        end
    end

    assign iaddr = addr[0];
    assign waddr = addr[1];

    // Jump pulses come from the weight walk only
    assign on_j0 = jump[1][0];
    assign on_j1 = jump[1][1];
    assign on_j2 = jump[1][2];

endmodule

`default_nettype wire

// ==== src/mvu_acc_timing.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "mvu_params.svh"

module mvu_acc_timing (
    input  logic   intf,
    input  logic   arst_n,
    mvu_cfg_if.acc cfg,
    input  logic   run,
    input  logic   on_j0,
    input  logic   on_j1,
    input  logic   on_j2,
    output logic   shacc_load,
    output logic   shacc_acc,
    output logic   quant_start
);

    localparam int PD = `MVU_PIPE_DELAY;
    localparam int QD = `MVU_POST_DELAY;

    logic                   trigger;        // Accumulation done on the selected jump
    logic [PD-1:0][2:0]     pipe_sr;        // {trigger, run, start_q} per stage
    logic [QD-1:0]          post_sr;        // Trigger through scaler and max pool

    always_comb begin
        trigger = 1'b0;
        if (run) begin
            case (cfg.load_sel)
                3'b001:  trigger = on_j0;
                3'b010:  trigger = on_j1;
                3'b100:  trigger = on_j2;
                default: trigger = 1'b0;    // Not one-hot
            endcase
        end
    end

    always_ff @(posedge intf or negedge arst_n) begin
        if (!arst_n) begin
            pipe_sr <= '0;
            post_sr <= '0;
        end else begin
            pipe_sr <= {pipe_sr[PD-2:0], {trigger, run, cfg.start_q}};
            post_sr <= {post_sr[QD-2:0], pipe_sr[PD-1][2]};
        end
    end

    // Load at job start and at every accumulation done
    assign shacc_load  = pipe_sr[PD-1][2] | pipe_sr[PD-1][0];
    assign shacc_acc   = pipe_sr[PD-1][1];
    assign quant_start = post_sr[QD-1];

endmodule

`default_nettype wire

// ==== src/mvu_out_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "mvu_params.svh"

module mvu_out_ctrl (
    input  logic           intf,
    input  logic           arst_n,
    mvu_cfg_if.out         cfg,
    input  logic           quant_start,
    output logic           out_step,
    output mvu_pkg::addr_t out_addr
);

    // Same retiming as the first result reaching the quantizer
    localparam int LOAD_DELAY = `MVU_PIPE_DELAY + `MVU_POST_DELAY + 1;

    logic [LOAD_DELAY-1:0] load_sr;
    logic                  out_load;    // Load obase into the output address
    mvu_pkg::prec_t        bit_cnt;     // Output bit in the current burst

    assign out_load = load_sr[LOAD_DELAY-1];

    always_ff @(posedge intf or negedge arst_n) begin
        if (!arst_n) begin
            load_sr  <= '0;
            out_step <= 1'b0;
            bit_cnt  <= '0;
        end else begin
            load_sr <= {load_sr[LOAD_DELAY-2:0], cfg.start_q};
            if (out_step) begin
                if (bit_cnt == cfg.oprec) begin
                    out_step <= 1'b0;   // Last bit of the burst
                end
                bit_cnt <= bit_cnt + 1'b1;
            end else if (quant_start) begin
                out_step <= 1'b1;
                bit_cnt  <= '0;
            end
        end
    end

    // One write per output bit
    always_ff @(posedge intf or negedge arst_n) begin
        if (!arst_n) begin
            out_addr <= '0;
        end else if (out_load) begin
            out_addr <= cfg.obase;
        end else if (out_step) begin
            out_addr <= out_addr + 1'b1;
        end
    end

    // Jump selection must leave room for a full burst
    a_no_overlap: assert property (@(posedge intf) disable iff (!arst_n)
        quant_start |-> !out_step)
        else $error("quant_start during an output burst");

endmodule

`default_nettype wire

// ==== src/mvu_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module mvu_top (
    input  logic               intf,
    input  logic               arst_n,
    input  logic               start,
    input  mvu_pkg::cnt_t      countdown,
    input  mvu_pkg::addr_t     ibase,
    input  mvu_pkg::addr_t     istride0,
    input  mvu_pkg::addr_t     istride1,
    input  mvu_pkg::len_t      ilen0,
    input  mvu_pkg::len_t      ilen1,
    input  mvu_pkg::addr_t     wbase,
    input  mvu_pkg::addr_t     wstride0,
    input  mvu_pkg::addr_t     wstride1,
    input  mvu_pkg::len_t      wlen0,
    input  mvu_pkg::len_t      wlen1,
    input  mvu_pkg::addr_t     obase,
    input  mvu_pkg::prec_t     oprec,
    input  mvu_pkg::jump_sel_t load_sel,
    output logic               run,
    output logic               done,
    output logic               irq,
    output mvu_pkg::addr_t     iaddr,
    output mvu_pkg::addr_t     waddr,
    output logic               shacc_load,
    output logic               shacc_acc,
    output logic               out_step,
    output mvu_pkg::addr_t     out_addr
);

    logic busy;         // Job in RUN or DONE
    logic on_j0;
    logic on_j1;
    logic on_j2;
    logic quant_start;

    mvu_cfg_if cfg_if ();

    mvu_cfg_buf u_cfg_buf (
        .intf      (intf),
        .arst_n    (arst_n),
        .start     (start),
        .busy      (busy),
        .countdown (countdown),
        .ibase     (ibase),
        .istride0  (istride0),
        .istride1  (istride1),
        .ilen0     (ilen0),
        .ilen1     (ilen1),
        .wbase     (wbase),
        .wstride0  (wstride0),
        .wstride1  (wstride1),
        .wlen0     (wlen0),
        .wlen1     (wlen1),
        .obase     (obase),
        .oprec     (oprec),
        .load_sel  (load_sel),
        .cfg       (cfg_if.pbuf)
    );

    mvu_job_ctrl u_job_ctrl (
        .intf   (intf),
        .arst_n (arst_n),
        .cfg    (cfg_if.ctrl),
        .busy   (busy),
        .run    (run),
        .done   (done),
        .irq    (irq)
    );

    mvu_addr_gen u_addr_gen (
        .intf   (intf),
        .arst_n (arst_n),
        .cfg    (cfg_if.agu),
        .run    (run),
        .iaddr  (iaddr),
        .waddr  (waddr),
        .on_j0  (on_j0),
        .on_j1  (on_j1),
        .on_j2  (on_j2)
    );

    mvu_acc_timing u_acc_timing (
        .intf        (intf),
        .arst_n      (arst_n),
        .cfg         (cfg_if.acc),
        .run         (run),
        .on_j0       (on_j0),
        .on_j1       (on_j1),
        .on_j2       (on_j2),
        .shacc_load  (shacc_load),
        .shacc_acc   (shacc_acc),
        .quant_start (quant_start)
    );

    mvu_out_ctrl u_out_ctrl (
        .intf        (intf),
        .arst_n      (arst_n),
        .cfg         (cfg_if.out),
        .quant_start (quant_start),
        .out_step    (out_step),
        .out_addr    (out_addr)
    );

endmodule

`default_nettype wire

// ==== tb/mvu_clk_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module mvu_clk_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 16
) (
    output logic intf,
    output logic arst_n
);

    initial begin
        intf = 1'b0;
        forever #(PERIOD_NS / 2) intf = ~intf;
    end

    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge intf);
        @(negedge intf);
        arst_n = 1'b1;      // Release away from the active edge
    end

endmodule

`default_nettype wire

// ==== tb/mvu_tb.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "mvu_params.svh"

module mvu_tb;

    localparam int PD              = `MVU_PIPE_DELAY;
    localparam int QD              = `MVU_POST_DELAY;
    localparam int CLK_PERIOD      = 20;
    localparam int RESET_CYCLES    = 16;
    localparam int ADDR_SPAN       = 1 << `MVU_BADDR;
    localparam int MAX_CYCLES      = 256;
    localparam int MAX_COUNT       = 55;    // 4 + largest 5 bit draw + longest weight walk
    localparam int NUM_JOBS        = 8;
    localparam int JOB_CYCLES      = MAX_COUNT + PD + QD + 26;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 4 + NUM_JOBS * JOB_CYCLES + 50;

    logic                intf;
    logic                arst_n;
    logic                start;
    mvu_pkg::cnt_t       countdown;
    mvu_pkg::addr_t      ibase, istride0, istride1, wbase, wstride0, wstride1, obase;
    mvu_pkg::len_t       ilen0, ilen1, wlen0, wlen1;
    mvu_pkg::prec_t      oprec;
    mvu_pkg::jump_sel_t  load_sel;
    logic                run, done, irq, shacc_load, shacc_acc, out_step;
    mvu_pkg::addr_t      iaddr, waddr, out_addr;

    // Job under test, channel 0 is input and channel 1 is weight
    int job_cnt, job_sel, job_obase, job_oprec;
    int job_base [2];
    int job_s0   [2];
    int job_s1   [2];
    int job_l0   [2];
    int job_l1   [2];

    // Reference model state, carried from job to job
    int m_addr [2];
    int m_idx0 [2];
    int m_idx1 [2];
    int m_oaddr = 0;
    int m_irq   = 0;
    logic [15:0] lfsr_state;

    int exp_run   [MAX_CYCLES];
    int exp_done  [MAX_CYCLES];
    int exp_irq   [MAX_CYCLES];
    int exp_iaddr [MAX_CYCLES];
    int exp_waddr [MAX_CYCLES];
    int exp_load  [MAX_CYCLES];
    int exp_acc   [MAX_CYCLES];
    int exp_step  [MAX_CYCLES];
    int exp_oaddr [MAX_CYCLES];

    mvu_clk_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) u_clk_gen (
        .intf   (intf),
        .arst_n (arst_n)
    );

    mvu_top u_mvu_top (
        .intf (intf), .arst_n (arst_n), .start (start), .countdown (countdown),
        .ibase (ibase), .istride0 (istride0), .istride1 (istride1),
        .ilen0 (ilen0), .ilen1 (ilen1),
        .wbase (wbase), .wstride0 (wstride0), .wstride1 (wstride1),
        .wlen0 (wlen0), .wlen1 (wlen1),
        .obase (obase), .oprec (oprec), .load_sel (load_sel),
        .run (run), .done (done), .irq (irq), .iaddr (iaddr), .waddr (waddr),
        .shacc_load (shacc_load), .shacc_acc (shacc_acc),
        .out_step (out_step), .out_addr (out_addr)
    );

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    // Galois LFSR, one step per bit taken
    function automatic int rand_bits(input int n);
        int v;
        int i;
        v = 0;
        for (i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
        end
        return v;
    endfunction

    // One step of the strided walk, returns the jump kind
    function automatic int walk_step(input int c);
        int kind;
        if (m_idx0[c] != job_l0[c]) begin
            m_idx0[c] = m_idx0[c] + 1;
            m_addr[c] = (m_addr[c] + job_s0[c]) % ADDR_SPAN;
            kind = 0;
        end else if (m_idx1[c] != job_l1[c]) begin
            m_idx0[c] = 0;
            m_idx1[c] = m_idx1[c] + 1;
            m_addr[c] = (m_addr[c] + job_s1[c]) % ADDR_SPAN;
            kind = 1;
        end else begin
            m_idx0[c] = 0;
            m_idx1[c] = 0;
            m_addr[c] = job_base[c];
            kind = 2;
        end
        return kind;
    endfunction

    task automatic make_job(input int sel);
        int c;
        job_sel   = sel;
        job_cnt   = 4 + rand_bits(5);
        job_obase = rand_bits(`MVU_BADDR);
        for (c = 0; c < 2; c++) begin
            job_base[c] = rand_bits(`MVU_BADDR);
            job_s0[c]   = rand_bits(`MVU_BADDR);
            job_s1[c]   = rand_bits(`MVU_BADDR);
            job_l0[c]   = rand_bits(2);
            job_l1[c]   = rand_bits(2);
        end
        // Weight lengths and precision keep output bursts apart
        case (sel)
            1: begin
                job_l0[1] = 1;
                job_oprec = 0;
            end
            2: begin
                job_l0[1] = 1 + rand_bits(2);
                job_l1[1] = 1 + rand_bits(1);
                job_oprec = rand_bits(2) % job_l0[1];
            end
            default: begin
                job_l0[1] = 1 + rand_bits(2);
                job_oprec = rand_bits(4) % ((job_l0[1] + 1) * (job_l1[1] + 1) - 1);
            end
        endcase
        // Run through at least one full weight walk so every jump kind shows up
        job_cnt = job_cnt + (job_l0[1] + 1) * (job_l1[1] + 1);
    endtask

    // Expected trace from cycle S (t = 0) onward
    task automatic build_trace(input int win);
        int t;
        int c;
        int kind;
        int rem;
        int quant;
        int trig [MAX_CYCLES];
        rem = 0;
        for (t = 0; t < win; t++) begin
            trig[t] = 0;
        end
        for (t = 0; t < win; t++) begin
            if (t == 2) begin
                for (c = 0; c < 2; c++) begin
                    m_addr[c] = job_base[c];
                    m_idx0[c] = 0;
                    m_idx1[c] = 0;
                end
                m_irq = 0;
            end
            if (t == 2 + job_cnt) begin
                m_irq = 1;
            end
            exp_run[t]   = (t >= 2 && t < 2 + job_cnt) ? 1 : 0;
            exp_done[t]  = (t == 2 + job_cnt) ? 1 : 0;
            exp_irq[t]   = m_irq;
            exp_iaddr[t] = m_addr[0];
            exp_waddr[t] = m_addr[1];
            if (exp_run[t] != 0) begin
                kind    = walk_step(0);
                kind    = walk_step(1);
                trig[t] = (job_sel >> kind) & 1;
            end
            exp_load[t] = (t == 1 + PD) ? 1 : ((t >= PD) ? trig[t - PD] : 0);
            exp_acc[t]  = (t >= PD) ? exp_run[t - PD] : 0;
            quant       = (t >= PD + QD) ? trig[t - PD - QD] : 0;
            exp_step[t] = (rem > 0) ? 1 : 0;
            exp_oaddr[t] = m_oaddr;
            if (quant != 0 && exp_step[t] != 0) begin
                report_failure("Test setup error: job configuration makes output bursts overlap");
            end
            if (rem > 0) begin
                rem = rem - 1;
            end
            if (quant != 0) begin
                rem = job_oprec + 1;
            end
            if (t == 2 + PD + QD) begin
                m_oaddr = job_obase;        // Output base load
            end else if (exp_step[t] != 0) begin
                m_oaddr = (m_oaddr + 1) % ADDR_SPAN;
            end
        end
    endtask

    task automatic check_value(input string test, input string sig, input int t,
                               input int exp, input int got);
        assert (got == exp)
            else report_failure($sformatf(
                "CHECK FAILED %s: %s at cycle S+%0d expected %0d actual %0d",
                test, sig, t, exp, got));
    endtask

    task automatic check_cycle(input string test, input int t);
        check_value(test, "run", t, exp_run[t], int'(run));
        check_value(test, "done", t, exp_done[t], int'(done));
        check_value(test, "irq", t, exp_irq[t], int'(irq));
        check_value(test, "iaddr", t, exp_iaddr[t], int'(iaddr));
        check_value(test, "waddr", t, exp_waddr[t], int'(waddr));
        check_value(test, "shacc_load", t, exp_load[t], int'(shacc_load));
        check_value(test, "shacc_acc", t, exp_acc[t], int'(shacc_acc));
        check_value(test, "out_step", t, exp_step[t], int'(out_step));
        check_value(test, "out_addr", t, exp_oaddr[t], int'(out_addr));
    endtask

    // A nonzero mask gives a configuration unlike the job's own
    task automatic drive_config(input int mask);
        countdown <= job_cnt[`MVU_BCNT-1:0] ^ mask[`MVU_BCNT-1:0];
        ibase     <= job_base[0][`MVU_BADDR-1:0] ^ mask[`MVU_BADDR-1:0];
        istride0  <= job_s0[0][`MVU_BADDR-1:0] ^ mask[`MVU_BADDR-1:0];
        istride1  <= job_s1[0][`MVU_BADDR-1:0] ^ mask[`MVU_BADDR-1:0];
        ilen0     <= job_l0[0][`MVU_BLEN-1:0] ^ mask[`MVU_BLEN-1:0];
        ilen1     <= job_l1[0][`MVU_BLEN-1:0] ^ mask[`MVU_BLEN-1:0];
        wbase     <= job_base[1][`MVU_BADDR-1:0] ^ mask[`MVU_BADDR-1:0];
        wstride0  <= job_s0[1][`MVU_BADDR-1:0] ^ mask[`MVU_BADDR-1:0];
        wstride1  <= job_s1[1][`MVU_BADDR-1:0] ^ mask[`MVU_BADDR-1:0];
        wlen0     <= job_l0[1][`MVU_BLEN-1:0] ^ mask[`MVU_BLEN-1:0];
        wlen1     <= job_l1[1][`MVU_BLEN-1:0] ^ mask[`MVU_BLEN-1:0];
        obase     <= job_obase[`MVU_BADDR-1:0] ^ mask[`MVU_BADDR-1:0];
        oprec     <= job_oprec[`MVU_BPREC-1:0] ^ mask[`MVU_BPREC-1:0];
        load_sel  <= job_sel[`MVU_NJUMPS-1:0] ^ mask[`MVU_NJUMPS-1:0];
    endtask

    // Starts the job in cycle S and checks every cycle until all outputs settle
    task automatic run_job(input string test, input int restart_at);
        int win;
        int t;
        win = job_cnt + PD + QD + 24;
        build_trace(win);
        @(posedge intf);
        start <= 1'b1;
        drive_config(0);
        for (t = 0; t < win; t++) begin
            @(negedge intf);
            check_cycle(test, t);
            @(posedge intf);
            if (t + 1 == restart_at) begin
                start <= 1'b1;
                drive_config(rand_bits(16) | 1);
            end else begin
                start <= 1'b0;
            end
        end
    endtask

    task automatic test_reset();
        int t;
        for (t = 0; t < 4; t++) begin
            @(negedge intf);
            check_value("reset", "run", t, 0, int'(run));
            check_value("reset", "done", t, 0, int'(done));
            check_value("reset", "irq", t, 0, int'(irq));
            check_value("reset", "iaddr", t, 0, int'(iaddr));
            check_value("reset", "waddr", t, 0, int'(waddr));
            check_value("reset", "shacc_load", t, 0, int'(shacc_load));
            check_value("reset", "shacc_acc", t, 0, int'(shacc_acc));
            check_value("reset", "out_step", t, 0, int'(out_step));
            check_value("reset", "out_addr", t, 0, int'(out_addr));
        end
    endtask

    task automatic test_run_irq();
        int i;
        for (i = 0; i < 2; i++) begin
            make_job(2);
            run_job("run_irq", -1);
        end
    endtask

    task automatic test_load_select();
        int i;
        for (i = 0; i < 3; i++) begin
            make_job(1 << i);
            run_job($sformatf("load_select_j%0d", i), -1);
        end
    endtask

    task automatic test_out_bursts();
        int i;
        for (i = 0; i < 2; i++) begin
            make_job(4);
            run_job("out_bursts", -1);
        end
    endtask

    task automatic test_start_while_busy();
        make_job(2);
        run_job("start_while_busy", 2 + job_cnt / 2);   // Second start lands mid run
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        report_failure("Watchdog expired before the tests finished");
    end

    initial begin
        start      = 1'b0;
        countdown  = '0;
        ibase      = '0;
        istride0   = '0;
        istride1   = '0;
        ilen0      = '0;
        ilen1      = '0;
        wbase      = '0;
        wstride0   = '0;
        wstride1   = '0;
        wlen0      = '0;
        wlen1      = '0;
        obase      = '0;
        oprec      = '0;
        load_sel   = '0;
        lfsr_state = 16'd40503;
        m_addr[0]  = 0;
        m_addr[1]  = 0;
        wait (arst_n === 1'b1);
        test_reset();
        test_run_irq();
        test_load_select();
        test_out_bursts();
        test_start_while_busy();
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+src
src/mvu_pkg.sv
src/mvu_cfg_if.sv
src/mvu_cfg_buf.sv
src/mvu_job_ctrl.sv
src/mvu_addr_gen.sv
src/mvu_acc_timing.sv
src/mvu_out_ctrl.sv
src/mvu_top.sv
tb/mvu_clk_gen.sv
tb/mvu_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the MVU control testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module mvu_tb -f flist.f -o mvu_sim

./obj_dir/mvu_sim
